// ==== src/ring_params_pkg.sv ====
// ring parameters for the banked key multiplier
// polynomial layout over the coefficient banks, coefficient width,
// modulus 12289 with its barrett constants, block latencies
package ring_params_pkg;

    // polynomial layout
    localparam int RING_SIZE   = 64;                     // coefficients per polynomial
    localparam int PE_NUMBER   = 4;                      // processing elements
    localparam int BANK_COUNT  = 2 * PE_NUMBER;          // even and odd bank per pe
    localparam int BANK_DEPTH  = RING_SIZE / BANK_COUNT; // words per region
    localparam int INDEX_WIDTH = $clog2(BANK_DEPTH);

    // coefficient arithmetic
    localparam int COEF_WIDTH = 14;
    localparam int PROD_WIDTH = 2 * COEF_WIDTH;  // full integer product
    localparam int RING_Q     = 12289;

    // barrett reduction, shift covers the whole 28-bit product
    localparam int BARRETT_SHIFT  = 28;
    localparam int BARRETT_FACTOR = (1 << BARRETT_SHIFT) / RING_Q;  // 21843
    localparam int FACTOR_WIDTH   = $clog2(BARRETT_FACTOR + 1);     // 15 bits

    // cycles
    localparam int READ_LATENCY = 1;  // registered bank read
    localparam int MULT_LATENCY = 3;  // product, quotient, remainder stages

endpackage

// ==== src/core_ctrl_pkg.sv ====
// controller types for the banked key multiplier
// state encoding, bank address word and its region codes, sequence lengths
package core_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_MULT,
        ST_DRAIN
    } ctrl_state_t;

    localparam int REGION_WIDTH = 2;
    localparam int ADDR_WIDTH   = REGION_WIDTH + ring_params_pkg::INDEX_WIDTH;

    localparam logic [REGION_WIDTH-1:0] REGION_INPUT  = 2'b00;  // loaded coefficients
    localparam logic [REGION_WIDTH-1:0] REGION_RESULT = 2'b10;  // key products

    // one address word, indexed flat by the memory, built by fields in the controller
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        struct packed {
            logic [REGION_WIDTH-1:0]                  region;
            logic [ring_params_pkg::INDEX_WIDTH-1:0] index;
        } field;
    } bank_addr_t;

    // sequence lengths in cycles
    localparam int LOAD_CYCLES  = ring_params_pkg::BANK_DEPTH;
    localparam int READ_CYCLES  = 2 * ring_params_pkg::BANK_DEPTH;  // even banks then odd
    localparam int WRITE_DELAY  = ring_params_pkg::READ_LATENCY + ring_params_pkg::MULT_LATENCY;
    localparam int MULT_CYCLES  = READ_CYCLES + WRITE_DELAY;
    localparam int DRAIN_CYCLES = ring_params_pkg::BANK_DEPTH + 1;  // one extra for read latency
    localparam int CNT_WIDTH    = $clog2(MULT_CYCLES);

endpackage

// ==== src/coef_bank.sv ====
`timescale 1ns/1ns
// coefficient bank, simple dual-port memory
// one write port, one read port with registered output
// input region and result region share the word space
module coef_bank
    import ring_params_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  write_en,
    input  bank_addr_t            write_addr,
    input  logic [COEF_WIDTH-1:0] write_data,
    input  bank_addr_t            read_addr,
    output logic [COEF_WIDTH-1:0] read_data
);

    // full address space, only two regions ever touched
    logic [COEF_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // write port
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr.flat] <= write_data;
        end
    end

    // read port, data one cycle after the address
    always_ff @(posedge clk) begin
        read_data <= mem[read_addr.flat];
    end

endmodule

// ==== src/mod_mult.sv ====
`timescale 1ns/1ns
// modular multiplier, operand times key mod RING_Q
// stage 1 integer product, stage 2 barrett quotient estimate,
// stage 3 remainder with a single correction step
module mod_mult
    import ring_params_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [COEF_WIDTH-1:0] operand,
    input  logic [COEF_WIDTH-1:0] key,
    output logic [COEF_WIDTH-1:0] product
);

    logic [PROD_WIDTH-1:0]              prod_s1;  // integer product
    logic [PROD_WIDTH-1:0]              prod_s2;  // product, aligned with quotient
    logic [FACTOR_WIDTH-1:0]            quot_s2;  // quotient estimate
    logic [PROD_WIDTH+FACTOR_WIDTH-1:0] scaled;   // product times barrett factor
    logic [PROD_WIDTH-1:0]              rem_raw;  // below 2q
    logic [PROD_WIDTH-1:0]              rem_fix;  // below q

    // estimate never exceeds the true quotient and misses it by one at most
    assign scaled = {{FACTOR_WIDTH{1'b0}}, prod_s1}
                  * {{PROD_WIDTH{1'b0}}, FACTOR_WIDTH'(BARRETT_FACTOR)};

    assign rem_raw = prod_s2
                   - {{(PROD_WIDTH-FACTOR_WIDTH){1'b0}}, quot_s2} * PROD_WIDTH'(RING_Q);

    // one conditional subtract is enough
    always_comb begin
        if (rem_raw >= PROD_WIDTH'(RING_Q)) begin
            rem_fix = rem_raw - PROD_WIDTH'(RING_Q);
        end else begin
            rem_fix = rem_raw;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_s1 <= '0;
            prod_s2 <= '0;
            quot_s2 <= '0;
            product <= '0;
        end else begin
            prod_s1 <= {{COEF_WIDTH{1'b0}}, operand} * {{COEF_WIDTH{1'b0}}, key};  // stage 1
            prod_s2 <= prod_s1;                                                     // stage 2
            quot_s2 <= scaled[BARRETT_SHIFT +: FACTOR_WIDTH];
            product <= rem_fix[COEF_WIDTH-1:0];                                     // stage 3
        end
    end

    // any operand pair, even above q, leaves a reduced word
    assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> product < COEF_WIDTH'(RING_Q))
        else $error("mod_mult product not reduced below the modulus");

endmodule

// ==== src/core_ctrl.sv ====
`timescale 1ns/1ns
// sequencer for the banked key multiplier
// idle, load, mult and drain states on one cycle counter;
// the counter is delayed by read plus multiply latency to time result writes
module core_ctrl
    import ring_params_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load_bram,
    input  logic       start,
    output logic       load_active,
    output logic       drain_active,
    output logic       write_even,
    output logic       write_odd,
    output bank_addr_t write_addr,
    output bank_addr_t read_addr,
    output logic       lane_odd,
    output logic       done
);

    ctrl_state_t          state;
    logic [CNT_WIDTH-1:0] cnt;
    logic                 last_cycle;   // final cycle of the current state
    logic                 read_phase;   // mult reads still going out
    logic [WRITE_DELAY:1] pipe_active;  // read slot on its way to the write
    logic [INDEX_WIDTH:0] pipe_cnt [1:WRITE_DELAY];  // odd-bank bit over index

    always_comb begin
        case (state)
            ST_LOAD:  last_cycle = cnt == CNT_WIDTH'(LOAD_CYCLES - 1);
            ST_MULT:  last_cycle = cnt == CNT_WIDTH'(MULT_CYCLES - 1);
            ST_DRAIN: last_cycle = cnt == CNT_WIDTH'(DRAIN_CYCLES - 1);
            default:  last_cycle = 1'b0;
        endcase
    end

    // state and counter, requests only taken in idle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (load_bram) begin
                        state <= ST_LOAD;  // load wins a tie
                    end else if (start) begin
                        state <= ST_MULT;
                    end
                end
                default: begin
                    if (last_cycle) begin
                        state <= (state == ST_MULT) ? ST_DRAIN : ST_IDLE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    assign read_phase = (state == ST_MULT) && (cnt < CNT_WIDTH'(READ_CYCLES));

    // delay line, stage 1 lines up with read data, last stage with the product
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pipe_active <= '0;
            for (int s = 1; s <= WRITE_DELAY; s++) begin
                pipe_cnt[s] <= '0;
            end
        end else begin
            pipe_active[1] <= read_phase;
            pipe_cnt[1]    <= cnt[INDEX_WIDTH:0];
            for (int s = 2; s <= WRITE_DELAY; s++) begin
                pipe_active[s] <= pipe_active[s-1];
                pipe_cnt[s]    <= pipe_cnt[s-1];
            end
        end
    end

    // done one cycle before the first result word leaves
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= (state == ST_DRAIN) && (cnt == '0);
        end
    end

    assign load_active  = state == ST_LOAD;
    assign drain_active = (state == ST_DRAIN) && (cnt != '0);  // read data valid
    assign lane_odd     = pipe_cnt[READ_LATENCY][INDEX_WIDTH];

    // load fills every bank, mult writes one side at a time
    assign write_even = load_active
                     || (pipe_active[WRITE_DELAY] && !pipe_cnt[WRITE_DELAY][INDEX_WIDTH]);
    assign write_odd  = load_active
                     || (pipe_active[WRITE_DELAY] && pipe_cnt[WRITE_DELAY][INDEX_WIDTH]);

    always_comb begin
        if (load_active) begin
            write_addr.field.region = REGION_INPUT;
            write_addr.field.index  = cnt[INDEX_WIDTH-1:0];
        end else begin
            write_addr.field.region = REGION_RESULT;  // product of delayed slot
            write_addr.field.index  = pipe_cnt[WRITE_DELAY][INDEX_WIDTH-1:0];
        end
    end

    // inputs during mult, results during drain
    always_comb begin
        read_addr.field.region = (state == ST_DRAIN) ? REGION_RESULT : REGION_INPUT;
        read_addr.field.index  = cnt[INDEX_WIDTH-1:0];
    end

    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held for more than one cycle");

    assert property (@(posedge clk) disable iff (reset)
        state == ST_MULT |-> !(write_even && write_odd))
        else $error("even and odd banks written together during mult");

    assert property (@(posedge clk) disable iff (reset)
        start && state != ST_IDLE && !last_cycle |=> state == $past(state))
        else $error("start while busy changed the state");

endmodule

// ==== src/ntt_key_core.sv ====
`timescale 1ns/1ns
// banked coefficient memory with pointwise key multiply mod 12289
// eight banks, two per processing element, one multiplier per element;
// results stream out one index per cycle after the done pulse
module ntt_key_core
    import ring_params_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             load_bram,
    input  logic                             start,
    input  logic [BANK_COUNT*COEF_WIDTH-1:0] bram_in,
    input  logic [PE_NUMBER*COEF_WIDTH-1:0]  secret_key,
    output logic                             done,
    output logic [BANK_COUNT*COEF_WIDTH-1:0] bram_out
);

    logic                  load_active;
    logic                  drain_active;
    logic                  write_even;
    logic                  write_odd;
    logic                  lane_odd;
    bank_addr_t            write_addr;
    bank_addr_t            read_addr;
    logic [COEF_WIDTH-1:0] bank_rdata [BANK_COUNT];
    logic [COEF_WIDTH-1:0] bank_wdata [BANK_COUNT];
    logic [COEF_WIDTH-1:0] pe_operand [PE_NUMBER];  // selected bank word
    logic [COEF_WIDTH-1:0] pe_product [PE_NUMBER];  // reduced product

    core_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .load_bram    (load_bram),
        .start        (start),
        .load_active  (load_active),
        .drain_active (drain_active),
        .write_even   (write_even),
        .write_odd    (write_odd),
        .write_addr   (write_addr),
        .read_addr    (read_addr),
        .lane_odd     (lane_odd),
        .done         (done)
    );

    // one multiplier per element, fed from its even or odd bank
    for (genvar p = 0; p < PE_NUMBER; p++) begin : g_pe
        assign pe_operand[p] = lane_odd ? bank_rdata[2*p+1] : bank_rdata[2*p];
        mod_mult u_mult (
            .clk     (clk),
            .reset   (reset),
            .operand (pe_operand[p]),
            .key     (secret_key[p*COEF_WIDTH +: COEF_WIDTH]),
            .product (pe_product[p])
        );
    end

    // bank b is lane b of the wide ports, owned by element b/2
    for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
        assign bank_wdata[b] = load_active ? bram_in[b*COEF_WIDTH +: COEF_WIDTH]
                                           : pe_product[b/2];
        coef_bank u_bank (
            .clk        (clk),
            .write_en   ((b % 2 == 1) ? write_odd : write_even),
            .write_addr (write_addr),
            .write_data (bank_wdata[b]),
            .read_addr  (read_addr),
            .read_data  (bank_rdata[b])
        );
    end

    // output word register, zero outside the drain window
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bram_out <= '0;
        end else if (drain_active) begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                bram_out[b*COEF_WIDTH +: COEF_WIDTH] <= bank_rdata[b];
            end
        end else begin
            bram_out <= '0;
        end
    end

endmodule

// ==== verif/ntt_key_core_tb.sv ====
`timescale 1ns/1ns
// testbench for the banked key multiplier
// loads polynomials, runs key multiplies from a table of rows,
// checks the drained result words against a modular product model
module ntt_key_core_tb
    import ring_params_pkg::*;
;

    localparam int          DRIVE_DELAY  = 10;   // ns after the rising edge
    localparam int          DONE_TIMEOUT = 100;  // cycles
    localparam int          DONE_CYCLE   = 21;   // 20 mult cycles, then the first drain read
    localparam int          NUM_TESTS    = 9;
    localparam logic [1:0]  DATA_RAMP    = 2'd0;  // explicit ramp of coefficients
    localparam logic [1:0]  DATA_LFSR    = 2'd1;
    localparam logic [1:0]  DATA_MAX     = 2'd2;  // every coefficient q-1
    localparam logic [15:0] KEY_RANDOM   = 16'hffff;  // key word drawn from the lfsr

    typedef struct packed {
        logic [1:0]       data_mode;
        logic [3:0][15:0] keys;    // key 3 down to key 0
        logic             reload;  // load fresh data first
        logic             early;   // extra start and load pulses while busy
    } test_row_t;

    logic                             clk;
    logic                             reset;
    logic                             load_bram;
    logic                             start;
    logic [BANK_COUNT*COEF_WIDTH-1:0] bram_in;
    logic [PE_NUMBER*COEF_WIDTH-1:0]  secret_key;
    logic                             done;
    logic [BANK_COUNT*COEF_WIDTH-1:0] bram_out;

    test_row_t   test_table [NUM_TESTS];
    int          model [BANK_COUNT][BANK_DEPTH];  // coefficients held in the input region
    int          cur_key [PE_NUMBER];
    logic [15:0] lfsr_state;
    int          error_count;
    int          done_count;
    int          pass_count;
    int          fail_count;

    ntt_key_core UUT (
        .clk        (clk),
        .reset      (reset),
        .load_bram  (load_bram),
        .start      (start),
        .bram_in    (bram_in),
        .secret_key (secret_key),
        .done       (done),
        .bram_out   (bram_out)
    );

    always #50 clk = ~clk;  // 100 ns period

    // done pulses seen mid-cycle
    always @(negedge clk) begin
        if (!reset && done) begin
            done_count <= done_count + 1;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic draw_coef(output int c);
        draw_bits(COEF_WIDTH, c);
        while (c >= RING_Q) begin
            draw_bits(COEF_WIDTH, c);  // retry until below q
        end
    endtask

    function automatic int lane_value(input logic [BANK_COUNT*COEF_WIDTH-1:0] word, input int b);
        return int'(word[b*COEF_WIDTH +: COEF_WIDTH]);
    endfunction

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("MISMATCH at %0t ns: %s, got %0d, expected %0d", $time, what, actual,
                     expected);
            error_count++;
        end
    endtask

    // ends at the drive point of the next cycle
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic load_poly(input logic [1:0] mode);
        int c;
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                case (mode)
                    DATA_RAMP: c = (b * BANK_DEPTH + i) * 193 + 5;  // stays below q
                    DATA_MAX:  c = RING_Q - 1;
                    default:   draw_coef(c);
                endcase
                model[b][i] = c;
            end
        end
        load_bram = 1'b1;
        next_cycle();
        load_bram = 1'b0;
        for (int i = 0; i < BANK_DEPTH; i++) begin
            for (int b = 0; b < BANK_COUNT; b++) begin
                bram_in[b*COEF_WIDTH +: COEF_WIDTH] = COEF_WIDTH'(model[b][i]);  // step i
            end
            next_cycle();
        end
        bram_in = '0;
    endtask

    // start pulse, then wait for done with a timeout
    task automatic run_multiply(input int t, input logic early, output logic got_done);
        got_done = 1'b0;
        start    = 1'b1;
        for (int k = 0; k < DONE_TIMEOUT && !got_done; k++) begin
            next_cycle();
            start     = 1'b0;
            load_bram = 1'b0;
            bram_in   = '0;
            if (done) begin
                got_done = 1'b1;
                check_value(k, DONE_CYCLE, $sformatf("test %0d cycles from start to done", t));
            end
            check_value(int'(|bram_out), 0, $sformatf("test %0d bram_out before results", t));
            if (early && k == 2) begin
                start = 1'b1;  // busy, must be dropped
            end
            if (early && k == 5) begin
                load_bram = 1'b1;
                bram_in   = '1;  // garbage that must never land
            end
        end
        if (!got_done) begin
            $display("ERROR: test %0d timed out after %0d cycles waiting for done", t,
                     DONE_TIMEOUT);
            error_count++;
        end
    endtask

    task automatic collect_results(input int t);
        int expected;
        for (int i = 0; i < BANK_DEPTH; i++) begin
            next_cycle();
            check_value(int'(done), 0, $sformatf("test %0d done during results", t));
            for (int b = 0; b < BANK_COUNT; b++) begin
                expected = (model[b][i] * cur_key[b/2]) % RING_Q;  // key of pe b/2
                check_value(lane_value(bram_out, b), expected,
                            $sformatf("test %0d lane %0d index %0d", t, b, i));
            end
        end
        // quiet window, no late words and no second done
        for (int k = 0; k < 24; k++) begin
            next_cycle();
            check_value(int'(|bram_out), 0, $sformatf("test %0d bram_out after results", t));
            check_value(int'(done), 0, $sformatf("test %0d extra done", t));
        end
    endtask

    initial begin
        test_row_t row;
        int        errors_before;
        int        done_before;
        logic      got_done;
        clk         = 1'b0;
        reset       = 1'b1;
        load_bram   = 1'b0;
        start       = 1'b0;
        bram_in     = '0;
        secret_key  = '0;
        lfsr_state  = 16'd49553;
        error_count = 0;
        done_count  = 0;
        pass_count  = 0;
        fail_count  = 0;

        test_table[0] = '{DATA_RAMP, {16'd1, 16'd1, 16'd1, 16'd1}, 1'b1, 1'b0};  // identity
        test_table[1] = '{DATA_LFSR, {4{KEY_RANDOM}}, 1'b1, 1'b0};
        test_table[2] = '{DATA_LFSR, {4{KEY_RANDOM}}, 1'b1, 1'b0};
        test_table[3] = '{DATA_MAX, {4{16'd12288}}, 1'b1, 1'b0};  // (q-1)^2 gives 1
        test_table[4] = '{DATA_MAX, {16'd0, 16'd12288, 16'd0, 16'd1}, 1'b0, 1'b0};
        test_table[5] = '{DATA_LFSR, {4{KEY_RANDOM}}, 1'b1, 1'b0};
        test_table[6] = '{DATA_LFSR, {4{KEY_RANDOM}}, 1'b0, 1'b0};  // old data, new keys
        test_table[7] = '{DATA_LFSR, {4{KEY_RANDOM}}, 1'b1, 1'b1};
        test_table[8] = '{DATA_LFSR, {16'd11, 16'd7, 16'd5, 16'd3}, 1'b0, 1'b1};

        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // idle after reset
        errors_before = error_count;
        for (int k = 0; k < 8; k++) begin
            next_cycle();
            check_value(int'(done), 0, "done after reset");
            check_value(int'(|bram_out), 0, "bram_out after reset");
        end
        check_value(done_count, 0, "done pulses after reset");
        if (error_count == errors_before) begin
            pass_count++;
            $display("test reset idle: pass");
        end else begin
            fail_count++;
            $display("test reset idle: FAIL");
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            row           = test_table[t];
            errors_before = error_count;
            done_before   = done_count;
            if (row.reload) begin
                load_poly(row.data_mode);
            end
            for (int p = 0; p < PE_NUMBER; p++) begin
                if (row.keys[p] == KEY_RANDOM) begin
                    draw_coef(cur_key[p]);
                end else begin
                    cur_key[p] = int'(row.keys[p]);
                end
                secret_key[p*COEF_WIDTH +: COEF_WIDTH] = COEF_WIDTH'(cur_key[p]);
            end
            run_multiply(t, row.early, got_done);
            if (got_done) begin
                collect_results(t);
            end
            check_value(done_count - done_before, 1, $sformatf("test %0d done pulses", t));
            if (error_count == errors_before) begin
                pass_count++;
                $display("test %0d: pass", t);
            end else begin
                fail_count++;
                $display("test %0d: FAIL", t);
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 pass_count + fail_count, pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== ntt_key_core.f ====
src/ring_params_pkg.sv
src/core_ctrl_pkg.sv
src/coef_bank.sv
src/mod_mult.sv
src/core_ctrl.sv
src/ntt_key_core.sv
verif/ntt_key_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ntt_key_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=ntt_key_core_sim

verilator --binary --timing --assert -Wno-fatal \
    -f ntt_key_core.f \
    --top-module ntt_key_core_tb \
    -Mdir obj_dir -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
    echo "no pass line in $LOG"
    exit 1
fi
exit 0
